// File: design/bp_pkg.sv
// Shared predictor constants and types; the queue widths assume BP_UPDATE_CREDITS of 2 or more
package bp_pkg;

  // Table geometry
  localparam int BP_ENTRIES     = 16;
  localparam int BP_INDEX_WIDTH = 4;

  // Counter shape for each entry
  localparam int BP_COUNT_RANGE = 8;
  localparam int BP_COUNT_WIDTH = 3;
  localparam int BP_COERCIVITY  = 1;

  // Weakly not-taken out of reset
  localparam int BP_COUNT_RESET = 3;

  // Upper half of the range predicts taken
  localparam int BP_TAKEN_THRESHOLD = 4;

  // Update queue depth, equal to the sender's starting credits
  localparam int BP_UPDATE_CREDITS = 4;

  // Queue pointer and occupancy widths follow from the depth
  localparam int BP_QUEUE_PTR_WIDTH = $clog2(BP_UPDATE_CREDITS);
  localparam int BP_QUEUE_OCC_WIDTH = $clog2(BP_UPDATE_CREDITS + 1);

  // Instruction address width
  localparam int PC_WIDTH = 32;

  // Program counter
  typedef logic [PC_WIDTH-1:0] pc_t;

  // Index into the counter table
  typedef logic [BP_INDEX_WIDTH-1:0] bp_index_t;

  // Value of one counter
  typedef logic [BP_COUNT_WIDTH-1:0] bp_count_t;

  // Folds two nibbles of the word address into a table index
  // Bits 1:0 are the byte offset and carry no information
  // Same hash on the lookup and update sides keeps both on one entry
  function automatic bp_index_t bp_index_of(input pc_t pc);
    bp_index_t low_bits;
    bp_index_t high_bits;
    low_bits  = pc[5:2];
    high_bits = pc[9:6];
    return low_bits ^ high_bits;
  endfunction

endpackage

// File: design/branch_predictor.sv
// Bimodal direction predictor without history, tags or flush; one table access per cycle
module branch_predictor
  import bp_pkg::*;
(
  input  logic clock,
  input  logic resetn,

  // Lookup channel
  input  logic lookup_valid,
  input  pc_t  lookup_pc,
  output logic predict_valid,
  output logic predict_taken,

  // Update channel with credit return
  input  logic update_valid,
  input  pc_t  update_pc,
  input  logic update_taken,
  output logic update_credit
);

  // Per-entry step strobes from the dispatcher
  logic [BP_ENTRIES-1:0] entry_increment;
  logic [BP_ENTRIES-1:0] entry_decrement;

  // All counts packed, entry i at slice i
  logic [BP_ENTRIES*BP_COUNT_WIDTH-1:0] entry_counts;

  // Update queue, stalled by lookups
  update_dispatch i_update_dispatch (
    .clock           (clock),
    .resetn          (resetn),
    .update_valid    (update_valid),
    .update_pc       (update_pc),
    .update_taken    (update_taken),
    .lookup_valid    (lookup_valid),
    .entry_increment (entry_increment),
    .entry_decrement (entry_decrement),
    .update_credit   (update_credit)
  );

  // Counter table
  for (genvar entry = 0; entry < BP_ENTRIES; entry++) begin : g_entry
    hysteresis_saturating_counter #(
      .RANGE       (BP_COUNT_RANGE),
      .COERCIVITY  (BP_COERCIVITY),
      .RESET_VALUE (BP_COUNT_RESET)
    ) i_counter (
      .clock     (clock),
      .resetn    (resetn),
      .increment (entry_increment[entry]),
      .decrement (entry_decrement[entry]),
      .count     (entry_counts[entry*BP_COUNT_WIDTH +: BP_COUNT_WIDTH])
    );
  end

  // Lookup side read port
  prediction_select i_prediction_select (
    .clock         (clock),
    .resetn        (resetn),
    .lookup_valid  (lookup_valid),
    .lookup_pc     (lookup_pc),
    .entry_counts  (entry_counts),
    .predict_valid (predict_valid),
    .predict_taken (predict_taken)
  );

endmodule

// File: design/hysteresis_saturating_counter.sv
// Count port is bp_count_t, so RANGE must fit in BP_COUNT_WIDTH bits; increment wins over decrement
module hysteresis_saturating_counter
  import bp_pkg::*;
#(
  parameter int RANGE       = 8,
  parameter int COERCIVITY  = 1,
  parameter int RESET_VALUE = 0
) (
  input  logic      clock,
  input  logic      resetn,
  input  logic      increment,
  input  logic      decrement,
  output bp_count_t count
);

  // Ends of the range
  localparam int COUNT_MIN = 0;
  localparam int COUNT_MAX = RANGE - 1;

  // The two values either side of the middle
  localparam int HALF_LOW  = RANGE / 2 - 1;
  localparam int HALF_HIGH = RANGE / 2;

  // Landing points of the hysteresis jump
  localparam int JUMP_LOW  = HALF_LOW - COERCIVITY;
  localparam int JUMP_HIGH = HALF_HIGH + COERCIVITY;

  logic at_min;
  logic at_max;
  logic at_half_low;
  logic at_half_high;

  // Position decode of the current count
  assign at_min       = (count == bp_count_t'(COUNT_MIN));
  assign at_max       = (count == bp_count_t'(COUNT_MAX));
  assign at_half_low  = (count == bp_count_t'(HALF_LOW));
  assign at_half_high = (count == bp_count_t'(HALF_HIGH));

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      count <= bp_count_t'(RESET_VALUE);
    end else if (increment && !at_max) begin
      // Crossing upward skips the gap
      if (at_half_low) begin
        count <= bp_count_t'(JUMP_HIGH);
      end else begin
        count <= count + 1'b1;
      end
    end else if (decrement && !at_min) begin
      // Crossing downward skips the gap
      if (at_half_high) begin
        count <= bp_count_t'(JUMP_LOW);
      end else begin
        count <= count - 1'b1;
      end
    end
    // Otherwise hold, including a saturated step
  end

endmodule

// File: design/prediction_select.sv
// Fixed one-cycle latency and no back-pressure; counts are read as they stand before the edge
module prediction_select
  import bp_pkg::*;
(
  input  logic                                 clock,
  input  logic                                 resetn,
  input  logic                                 lookup_valid,
  input  pc_t                                  lookup_pc,
  input  logic [BP_ENTRIES*BP_COUNT_WIDTH-1:0] entry_counts,
  output logic                                 predict_valid,
  output logic                                 predict_taken
);

  bp_index_t lookup_index;
  bp_count_t selected_count;
  logic      count_taken;

  // Same hash as the update side
  assign lookup_index = bp_index_of(lookup_pc);

  // Slice the flat count bus at the indexed entry
  assign selected_count = entry_counts[lookup_index*BP_COUNT_WIDTH +: BP_COUNT_WIDTH];

  // Upper half of the counter means taken
  assign count_taken = (selected_count >= bp_count_t'(BP_TAKEN_THRESHOLD));

  // Valid follows the lookup by one cycle
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      predict_valid <= 1'b0;
    end else begin
      predict_valid <= lookup_valid;
    end
  end

  // Direction held low when no lookup
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      predict_taken <= 1'b0;
    end else begin
      predict_taken <= lookup_valid && count_taken;
    end
  end

endmodule

// File: design/update_dispatch.sv
// Queue never overflows only if the sender honours its credits; lookups stall retirement
module update_dispatch
  import bp_pkg::*;
(
  input  logic                  clock,
  input  logic                  resetn,
  input  logic                  update_valid,
  input  pc_t                   update_pc,
  input  logic                  update_taken,
  input  logic                  lookup_valid,
  output logic [BP_ENTRIES-1:0] entry_increment,
  output logic [BP_ENTRIES-1:0] entry_decrement,
  output logic                  update_credit
);

  // Last slot, where the pointers wrap
  localparam int LAST_SLOT = BP_UPDATE_CREDITS - 1;

  // Queue storage, one index and direction per slot
  bp_index_t queue_index [BP_UPDATE_CREDITS];
  logic      queue_taken [BP_UPDATE_CREDITS];

  // Queue control
  logic [BP_QUEUE_PTR_WIDTH-1:0] write_ptr;
  logic [BP_QUEUE_PTR_WIDTH-1:0] read_ptr;
  logic [BP_QUEUE_OCC_WIDTH-1:0] occupancy;

  logic      queue_empty;
  logic      retire;
  bp_index_t head_index;
  logic      head_taken;

  assign queue_empty = (occupancy == '0);

  // Table port is free only without a lookup
  assign retire = !queue_empty && !lookup_valid;

  // Oldest pending update
  assign head_index = queue_index[read_ptr];
  assign head_taken = queue_taken[read_ptr];

  // Hash on entry so the queue holds only the index
  always_ff @(posedge clock) begin
    if (update_valid) begin
      queue_index[write_ptr] <= bp_index_of(update_pc);
      queue_taken[write_ptr] <= update_taken;
    end
  end

  // Write side advances on every accepted update
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      write_ptr <= '0;
    end else if (update_valid) begin
      if (write_ptr == BP_QUEUE_PTR_WIDTH'(LAST_SLOT)) begin
        write_ptr <= '0;
      end else begin
        write_ptr <= write_ptr + 1'b1;
      end
    end
  end

  // Read side advances on every retirement
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      read_ptr <= '0;
    end else if (retire) begin
      if (read_ptr == BP_QUEUE_PTR_WIDTH'(LAST_SLOT)) begin
        read_ptr <= '0;
      end else begin
        read_ptr <= read_ptr + 1'b1;
      end
    end
  end

  // Occupancy tracks push and pop together
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      occupancy <= '0;
    end else begin
      case ({update_valid, retire})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

  // One-hot step toward the branch outcome
  always_comb begin
    entry_increment = '0;
    entry_decrement = '0;
    if (retire) begin
      if (head_taken) begin
        entry_increment[head_index] = 1'b1;
      end else begin
        entry_decrement[head_index] = 1'b1;
      end
    end
  end

  // Credit goes back in the cycle after the slot frees
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      update_credit <= 1'b0;
    end else begin
      update_credit <= retire;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
  --top-module tb_branch_predictor -f vlog.f -o sim_branch_predictor

# A failing run still prints, the search decides the verdict
output=$(./obj_dir/sim_branch_predictor || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Result: PASSED"; then
  exit 0
else
  exit 1
fi

// File: sim/branch_predictor_assert.sv
// Checker bound into branch_predictor; the queue model wraps its 2-bit pointers, so depth 4 only
module branch_predictor_assert
  import bp_pkg::*;
(
  input logic                                 clock,
  input logic                                 resetn,
  input logic                                 lookup_valid,
  input pc_t                                  lookup_pc,
  input logic                                 predict_valid,
  input logic                                 predict_taken,
  input logic                                 update_valid,
  input pc_t                                  update_pc,
  input logic                                 update_taken,
  input logic                                 update_credit,
  input logic [BP_ENTRIES*BP_COUNT_WIDTH-1:0] entry_counts
);
  timeunit 1ns;
  timeprecision 1ps;

  // Reference table, same packing as the DUT count bus
  logic [BP_ENTRIES*BP_COUNT_WIDTH-1:0] ref_counts;

  // Reference update queue
  bp_index_t                     ref_slot [BP_UPDATE_CREDITS];
  logic                          ref_dir  [BP_UPDATE_CREDITS];
  logic [BP_QUEUE_PTR_WIDTH-1:0] ref_head;
  logic [BP_QUEUE_PTR_WIDTH-1:0] ref_tail;
  int                            ref_fill;

  // Expected registered outputs
  logic exp_valid;
  logic exp_taken;
  logic exp_credit;

  // Credits held by the sender, as seen at each edge
  int sender_credits;
  logic retire_now;

  // Read by the testbench top to end the run
  int failure_count = 0;

  // Index is word-address bits 5:2 folded with bits 9:6
  function automatic bp_index_t slot_of(input pc_t pc);
    return pc[5:2] ^ pc[9:6];
  endfunction

  // Counter rule, 0 to 7, jumping 3 to 5 upward and 4 to 2 downward
  function automatic bp_count_t stepped_count(input bp_count_t count, input logic taken);
    bp_count_t result;
    result = count;
    if (taken) begin
      if (count == 3'd3) begin
        result = 3'd5;
      end else if (count != 3'd7) begin
        result = count + 3'd1;
      end
    end else begin
      if (count == 3'd4) begin
        result = 3'd2;
      end else if (count != 3'd0) begin
        result = count - 3'd1;
      end
    end
    return result;
  endfunction

  // Table port free only without a lookup
  assign retire_now = (ref_fill != 0) && !lookup_valid;

  always @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      ref_counts     <= {BP_ENTRIES{3'd3}};
      ref_head       <= '0;
      ref_tail       <= '0;
      ref_fill       <= 0;
      exp_valid      <= 1'b0;
      exp_taken      <= 1'b0;
      exp_credit     <= 1'b0;
      sender_credits <= BP_UPDATE_CREDITS;
    end else begin
      // Prediction sees the counts before this edge
      exp_valid  <= lookup_valid;
      exp_taken  <= lookup_valid &&
                    (ref_counts[slot_of(lookup_pc)*BP_COUNT_WIDTH +: BP_COUNT_WIDTH] >= 3'd4);
      exp_credit <= retire_now;
      if (retire_now) begin
        ref_counts[ref_slot[ref_head]*BP_COUNT_WIDTH +: BP_COUNT_WIDTH] <= stepped_count(
          ref_counts[ref_slot[ref_head]*BP_COUNT_WIDTH +: BP_COUNT_WIDTH], ref_dir[ref_head]);
        ref_head <= ref_head + 1'b1;
      end
      if (update_valid) begin
        ref_slot[ref_tail] <= slot_of(update_pc);
        ref_dir[ref_tail]  <= update_taken;
        ref_tail           <= ref_tail + 1'b1;
      end
      ref_fill       <= ref_fill + int'(update_valid) - int'(retire_now);
      sender_credits <= sender_credits + int'(update_credit) - int'(update_valid);
    end
  end

  a_predict_valid: assert property (@(posedge clock) disable iff (!resetn)
    predict_valid == exp_valid)
    else begin
      failure_count = failure_count + 1;
      $error("mismatch predict_valid: expected %0b actual %0b",
             $sampled(exp_valid), $sampled(predict_valid));
    end

  a_predict_taken: assert property (@(posedge clock) disable iff (!resetn)
    predict_valid |-> predict_taken == exp_taken)
    else begin
      failure_count = failure_count + 1;
      $error("mismatch predict_taken: expected %0b actual %0b",
             $sampled(exp_taken), $sampled(predict_taken));
    end

  a_update_credit: assert property (@(posedge clock) disable iff (!resetn)
    update_credit == exp_credit)
    else begin
      failure_count = failure_count + 1;
      $error("mismatch update_credit: expected %0b actual %0b",
             $sampled(exp_credit), $sampled(update_credit));
    end

  // Covers hysteresis, saturation, stall and retirement order
  a_table_counts: assert property (@(posedge clock) disable iff (!resetn)
    entry_counts == ref_counts)
    else begin
      failure_count = failure_count + 1;
      $error("mismatch table_counts: expected %h actual %h",
             $sampled(ref_counts), $sampled(entry_counts));
    end

  a_queue_bound: assert property (@(posedge clock) disable iff (!resetn)
    ref_fill <= BP_UPDATE_CREDITS)
    else begin
      failure_count = failure_count + 1;
      $error("more than %0d updates are outstanding", BP_UPDATE_CREDITS);
    end

  // A pulse in this cycle may be spent at once
  a_update_credit_held: assert property (@(posedge clock) disable iff (!resetn)
    update_valid |-> (sender_credits + int'(update_credit)) > 0)
    else begin
      failure_count = failure_count + 1;
      $error("an update arrived while the sender held no credit");
    end

endmodule

bind branch_predictor branch_predictor_assert i_assert (
  .clock         (clock),
  .resetn        (resetn),
  .lookup_valid  (lookup_valid),
  .lookup_pc     (lookup_pc),
  .predict_valid (predict_valid),
  .predict_taken (predict_taken),
  .update_valid  (update_valid),
  .update_pc     (update_pc),
  .update_taken  (update_taken),
  .update_credit (update_credit),
  .entry_counts  (entry_counts)
);

// File: sim/clock_gen.sv
// Free-running 40 ns clock; resetn is low for the first 5 rising edges, released on a falling edge
module clock_gen (
  output logic clock,
  output logic resetn
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 5;

  initial begin
    clock = 1'b0;
    forever #(HALF_PERIOD) clock = ~clock;
  end

  // Release away from the rising edge
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    resetn = 1'b1;
  end

endmodule

// File: sim/tb_branch_predictor.sv
// Drives on falling edges and counts credits as a sender would; bound assertions do all checking
module tb_branch_predictor
  import bp_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT    = 64;
  localparam int RANDOM_CYCLES = 400;

  logic clock;
  logic resetn;
  logic lookup_valid;
  pc_t  lookup_pc;
  logic predict_valid;
  logic predict_taken;
  logic update_valid;
  pc_t  update_pc;
  logic update_taken;
  logic update_credit;

  logic [31:0] rng_state = 32'he91;
  int          credits = BP_UPDATE_CREDITS;
  logic        fail_reported = 1'b0;
  logic        run_finished = 1'b0;

  clock_gen i_clock_gen (.clock(clock), .resetn(resetn));

  branch_predictor i_dut (
    .clock         (clock),
    .resetn        (resetn),
    .lookup_valid  (lookup_valid),
    .lookup_pc     (lookup_pc),
    .predict_valid (predict_valid),
    .predict_taken (predict_taken),
    .update_valid  (update_valid),
    .update_pc     (update_pc),
    .update_taken  (update_taken),
    .update_credit (update_credit)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Four aliases per index through bits 7:6, upper bits free
  function automatic pc_t alias_pc(input bp_index_t index, input logic [31:0] noise);
    bp_index_t high;
    high = {2'b00, noise[1:0]};
    return {noise[31:10], high, index ^ high, 2'b00};
  endfunction

  task automatic announce_failure(input string reason);
    $display("%s", reason);
    fail_reported = 1'b1;
    $display("Result: FAILED");
  endtask

  // One cycle of stimulus; the update goes out only with a credit in hand
  task automatic drive_cycle(input logic lookup, input pc_t lpc, input logic update,
                             input pc_t upc, input logic utaken, output logic sent);
    @(negedge clock);
    if (update_credit) begin
      credits = credits + 1;
    end
    sent         = update && (credits > 0);
    lookup_valid = lookup;
    lookup_pc    = lpc;
    update_valid = sent;
    update_pc    = upc;
    update_taken = utaken;
    if (sent) begin
      credits = credits - 1;
    end
  endtask

  task automatic predict_lookup(input pc_t pc);
    logic sent;
    drive_cycle(1'b1, pc, 1'b0, '0, 1'b0, sent);
  endtask

  task automatic send_update(input pc_t pc, input logic taken);
    logic sent;
    int   tries;
    sent  = 1'b0;
    tries = 0;
    while (!sent) begin
      drive_cycle(1'b0, '0, 1'b1, pc, taken, sent);
      tries = tries + 1;
      if (!sent && tries > WAIT_LIMIT) begin
        announce_failure("no credit came back for a pending update");
        $fatal(1, "credit timeout");
      end
    end
  endtask

  // Idle until every credit is home, so the queue is empty
  task automatic wait_drained();
    logic sent;
    int   cycles;
    cycles = 0;
    while (credits != BP_UPDATE_CREDITS) begin
      drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, sent);
      cycles = cycles + 1;
      if (cycles > WAIT_LIMIT) begin
        announce_failure("queued updates did not retire in time");
        $fatal(1, "drain timeout");
      end
    end
  endtask

  task automatic send_run(input int count, input logic taken);
    for (int n = 0; n < count; n++) begin
      rng_state = xorshift32(rng_state);
      send_update(alias_pc(4'd5, rng_state), taken);
    end
    wait_drained();
    rng_state = xorshift32(rng_state);
    predict_lookup(alias_pc(4'd5, rng_state));
  endtask

  // Stop at the first assertion failure
  always @(negedge clock) begin
    if (i_dut.i_assert.failure_count != 0 && !fail_reported) begin
      announce_failure("an assertion in the predictor checker failed");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    pc_t  first_pc;
    pc_t  second_pc;
    logic sent;
    int   wait_cycles;
    lookup_valid = 1'b0;
    lookup_pc    = '0;
    update_valid = 1'b0;
    update_pc    = '0;
    update_taken = 1'b0;

    wait_cycles = 0;
    while (resetn !== 1'b1) begin
      @(negedge clock);
      wait_cycles = wait_cycles + 1;
      if (wait_cycles > WAIT_LIMIT) begin
        announce_failure("reset was never released");
        $fatal(1, "reset timeout");
      end
    end

    // Quiet outputs, then lookups on the reset table
    repeat (3) drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, sent);
    for (int n = 0; n < 8; n++) begin
      rng_state = xorshift32(rng_state);
      predict_lookup(alias_pc(rng_state[7:4], rng_state >> 8));
    end

    // Hysteresis, 3 to 5 then 5 to 4
    send_run(1, 1'b1);
    send_run(1, 1'b0);
    // Saturate at 7, then one step back stays taken
    send_run(10, 1'b1);
    send_run(1, 1'b0);
    // Saturate at 0, then one step up stays not-taken
    send_run(12, 1'b0);
    send_run(1, 1'b1);

    // Held lookups stall the queue and exhaust the credits
    for (int n = 0; n < 16; n++) begin
      rng_state = xorshift32(rng_state);
      first_pc  = alias_pc(rng_state[7:4], rng_state >> 8);
      rng_state = xorshift32(rng_state);
      second_pc = alias_pc(rng_state[11:8], rng_state);
      drive_cycle(1'b1, first_pc, 1'b1, second_pc, rng_state[4], sent);
    end
    wait_drained();

    // Random mix of lookups and updates
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      rng_state = xorshift32(rng_state);
      first_pc  = alias_pc(rng_state[7:4], rng_state >> 8);
      rng_state = xorshift32(rng_state);
      second_pc = alias_pc(rng_state[11:8], rng_state);
      drive_cycle(rng_state[12], first_pc, rng_state[13], second_pc, rng_state[14], sent);
    end
    wait_drained();
    repeat (4) drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, sent);

    run_finished = 1'b1;
    if (i_dut.i_assert.failure_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      announce_failure("assertion failures were recorded during the run");
      $fatal(1, "run failed");
    end
  end

  // Simulator stopped early, for instance on an assertion error
  final begin
    if (!run_finished && !fail_reported) begin
      $display("Result: FAILED");
    end
  end

endmodule

// File: vlog.f
design/bp_pkg.sv
design/hysteresis_saturating_counter.sv
design/update_dispatch.sv
design/prediction_select.sv
design/branch_predictor.sv
sim/clock_gen.sv
sim/branch_predictor_assert.sv
sim/tb_branch_predictor.sv
